// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_mem_system
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Address and data widths
`define CACHE_ADDR_W 16
`define CACHE_DATA_W 16

// Direct-mapped split, tag on top
`define CACHE_INDEX_W 6
`define CACHE_TAG_W 10

// One word per line
`define CACHE_LINES 64

// Cycles busy stays nonzero after a memory pulse
`define MEM_LATENCY 4

`endif

// File: rtl/cache_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module cache_array import cache_pkg::*; (
   input  wire logic                     clk,
   input  wire logic                     rst,
   input  wire logic                     en,
   input  wire logic                     comp,
   input  wire logic                     cache_wr,
   input  wire cache_addr_t              addr,
   input  wire logic [`CACHE_DATA_W-1:0] wdata,
   output cache_lookup_t                 lookup
);

   logic [`CACHE_TAG_W-1:0]  tag_mem  [0:`CACHE_LINES-1];
   logic [`CACHE_DATA_W-1:0] data_mem [0:`CACHE_LINES-1];
   logic [`CACHE_LINES-1:0]  valid_q;
   logic [`CACHE_LINES-1:0]  dirty_q;

   logic [`CACHE_INDEX_W-1:0] idx;
   logic                      tag_eq;
   logic                      line_hit;

   assign idx      = addr.split.index;
   assign tag_eq   = (tag_mem[idx] == addr.split.tag);
   assign line_hit = tag_eq & valid_q[idx];

   // Valid and dirty flags
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (cache_wr) begin
         if (!comp) begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= 1'b0; // Fresh copy of memory
         end else if (line_hit) begin
            dirty_q[idx] <= 1'b1;
         end
      end
   end

   // Tag and data storage
   always_ff @(posedge clk) begin
      if (cache_wr) begin
         if (!comp) begin
            tag_mem[idx]  <= addr.split.tag;
            data_mem[idx] <= wdata;
         end else if (line_hit) begin
            data_mem[idx] <= wdata;
         end
      end
   end

   // Lookup sampled before any same-cycle write
   always_ff @(posedge clk) begin
      if (rst) begin
         lookup <= '0;
      end else if (en) begin
         lookup.hit        <= tag_eq;
         lookup.valid      <= valid_q[idx];
         lookup.dirty      <= dirty_q[idx];
         lookup.victim_tag <= tag_mem[idx];
         lookup.rdata      <= data_mem[idx];
      end
   end

endmodule

`default_nettype wire

// File: rtl/cache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module cache_ctrl import cache_pkg::*; (
   input  wire logic                     clk,
   input  wire logic                     rst,
   input  wire cache_req_t               req,
   input  wire cache_lookup_t            lookup,
   input  wire logic [3:0]               busy,
   input  wire logic [`CACHE_DATA_W-1:0] mem_rdata,
   output logic [`CACHE_DATA_W-1:0]      data_out,
   output logic                          cache_hit,
   output logic                          done,
   output logic                          stall,
   output logic                          err,
   output logic                          en,
   output logic                          comp,
   output logic                          cache_wr,
   output cache_addr_t                   array_addr,
   output logic [`CACHE_DATA_W-1:0]      array_wdata,
   output logic                          mem_rd,
   output logic                          mem_wr,
   output cache_addr_t                   mem_addr,
   output logic [`CACHE_DATA_W-1:0]      mem_wdata
);

   localparam logic [3:0] IDLE      = 4'b0000;
   localparam logic [3:0] CMP_WR    = 4'b0001;
   localparam logic [3:0] CMP_RD    = 4'b0010;
   localparam logic [3:0] ACCESS_RD = 4'b0011;
   localparam logic [3:0] MEM_WR    = 4'b0100;
   localparam logic [3:0] MEM_RD    = 4'b0101;
   localparam logic [3:0] ACCESS_WR = 4'b0110;
   localparam logic [3:0] MISS_WR   = 4'b0111;
   localparam logic [3:0] MISS_RD   = 4'b1000;

   logic [3:0] state;
   logic [3:0] next_state;
   logic       line_hit;

   assign line_hit = lookup.hit & lookup.valid;

   always_ff @(posedge clk) begin
      if (rst)
         state <= IDLE;
      else
         state <= next_state;
   end

   // Lookup result and memory data go straight through
   assign data_out   = lookup.rdata;
   assign mem_wdata  = lookup.rdata;
   assign array_addr = req.addr;
   assign array_wdata = comp ? req.wdata : mem_rdata; // Fill takes memory data
   assign stall      = (state != IDLE);

   always_comb begin
      next_state = state;
      cache_hit  = 1'b0;
      done       = 1'b0;
      err        = 1'b0;
      en         = 1'b0;
      comp       = 1'b0;
      cache_wr   = 1'b0;
      mem_rd     = 1'b0;
      mem_wr     = 1'b0;
      mem_addr   = req.addr;

      case (state)
         IDLE: begin
            if (req.read) begin
               en         = 1'b1;
               comp       = 1'b1;
               next_state = CMP_RD;
            end else if (req.write) begin
               en         = 1'b1;
               comp       = 1'b1;
               cache_wr   = 1'b1; // Lands only if the line hits
               next_state = CMP_WR;
            end
         end
         CMP_WR: begin
            if (line_hit) begin
               cache_hit  = 1'b1;
               done       = 1'b1;
               next_state = IDLE;
            end else begin
               next_state = ACCESS_RD;
            end
         end
         CMP_RD: begin
            if (line_hit) begin
               cache_hit  = 1'b1;
               done       = 1'b1;
               next_state = IDLE;
            end else begin
               next_state = ACCESS_RD;
            end
         end
         ACCESS_RD: begin
            if (lookup.valid & lookup.dirty) begin
               // Victim goes back to its own address
               mem_wr               = 1'b1;
               mem_addr.split.tag   = lookup.victim_tag;
               mem_addr.split.index = req.addr.split.index;
               next_state           = MEM_WR;
            end else begin
               mem_rd     = 1'b1;
               next_state = MEM_RD;
            end
         end
         MEM_WR: begin
            if (busy == 4'd0) begin
               mem_rd     = 1'b1; // Write-back done, start the fill
               next_state = MEM_RD;
            end
         end
         MEM_RD: begin
            if (busy == 4'd0) begin
               cache_wr   = 1'b1;
               next_state = ACCESS_WR;
            end
         end
         ACCESS_WR: begin
            // Retry now hits the filled line
            if (req.write) begin
               en         = 1'b1;
               comp       = 1'b1;
               cache_wr   = 1'b1;
               next_state = MISS_WR;
            end else begin
               en         = 1'b1;
               comp       = 1'b1;
               next_state = MISS_RD;
            end
         end
         MISS_WR: begin
            done       = 1'b1;
            next_state = IDLE;
         end
         MISS_RD: begin
            done       = 1'b1;
            next_state = IDLE;
         end
         default: begin
            err        = 1'b1;
            next_state = IDLE;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/cache_pkg.sv
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

   typedef struct packed {
      logic [`CACHE_TAG_W-1:0]   tag;
      logic [`CACHE_INDEX_W-1:0] index;
   } cache_tag_idx_t;

   // Same word, flat or split into tag and index
   typedef union packed {
      logic [`CACHE_ADDR_W-1:0] word;
      cache_tag_idx_t           split;
   } cache_addr_t;

   typedef struct packed {
      cache_addr_t              addr;
      logic [`CACHE_DATA_W-1:0] wdata;
      logic                     read;
      logic                     write;
   } cache_req_t;

   typedef struct packed {
      logic                     hit;
      logic                     valid;
      logic                     dirty;
      logic [`CACHE_TAG_W-1:0]  victim_tag;
      logic [`CACHE_DATA_W-1:0] rdata;
   } cache_lookup_t;

endpackage

`default_nettype wire

// File: rtl/main_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module main_mem import cache_pkg::*; (
   input  wire logic                     clk,
   input  wire logic                     rst,
   input  wire logic                     mem_rd,
   input  wire logic                     mem_wr,
   input  wire cache_addr_t              addr,
   input  wire logic [`CACHE_DATA_W-1:0] wdata,
   output logic [3:0]                    busy,
   output logic [`CACHE_DATA_W-1:0]      rdata
);

   localparam int                       WORDS    = 1 << `CACHE_ADDR_W;
   localparam logic [`CACHE_DATA_W-1:0] INIT_XOR = 16'h5a5a;
   localparam logic [3:0]               BUSY_SET = 4'((1 << `MEM_LATENCY) - 1);

   logic [`CACHE_DATA_W-1:0] mem [0:WORDS-1];

   // Word array, preset to a known pattern on reset
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < WORDS; i++)
            mem[i] <= i[`CACHE_DATA_W-1:0] ^ INIT_XOR;
      end else if (mem_wr) begin
         mem[addr.word] <= wdata;
      end
   end

   // Read data captured at the pulse and held
   always_ff @(posedge clk) begin
      if (mem_rd)
         rdata <= mem[addr.word];
   end

   // One bit drops out per cycle
   always_ff @(posedge clk) begin
      if (rst)
         busy <= '0;
      else if (mem_rd | mem_wr)
         busy <= BUSY_SET;
      else
         busy <= busy >> 1;
   end

endmodule

`default_nettype wire

// File: rtl/mem_system.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module mem_system import cache_pkg::*; (
   input  wire logic                clk,
   input  wire logic                rst,
   input  wire cache_req_t          req,
   output logic [`CACHE_DATA_W-1:0] data_out,
   output logic                     cache_hit,
   output logic                     done,
   output logic                     stall,
   output logic                     err
);

   cache_lookup_t            lookup;
   logic                     en;
   logic                     comp;
   logic                     cache_wr;
   cache_addr_t              array_addr;
   logic [`CACHE_DATA_W-1:0] array_wdata;
   logic                     mem_rd;
   logic                     mem_wr;
   cache_addr_t              mem_addr;
   logic [`CACHE_DATA_W-1:0] mem_wdata;
   logic [3:0]               busy;
   logic [`CACHE_DATA_W-1:0] mem_rdata;

   cache_ctrl i_ctrl (
      .clk         (clk),
      .rst         (rst),
      .req         (req),
      .lookup      (lookup),
      .busy        (busy),
      .mem_rdata   (mem_rdata),
      .data_out    (data_out),
      .cache_hit   (cache_hit),
      .done        (done),
      .stall       (stall),
      .err         (err),
      .en          (en),
      .comp        (comp),
      .cache_wr    (cache_wr),
      .array_addr  (array_addr),
      .array_wdata (array_wdata),
      .mem_rd      (mem_rd),
      .mem_wr      (mem_wr),
      .mem_addr    (mem_addr),
      .mem_wdata   (mem_wdata)
   );

   cache_array i_array (
      .clk      (clk),
      .rst      (rst),
      .en       (en),
      .comp     (comp),
      .cache_wr (cache_wr),
      .addr     (array_addr),
      .wdata    (array_wdata),
      .lookup   (lookup)
   );

   main_mem i_mem (
      .clk    (clk),
      .rst    (rst),
      .mem_rd (mem_rd),
      .mem_wr (mem_wr),
      .addr   (mem_addr),
      .wdata  (mem_wdata),
      .busy   (busy),
      .rdata  (mem_rdata)
   );

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
rtl/cache_pkg.sv
rtl/main_mem.sv
rtl/cache_array.sv
rtl/cache_ctrl.sv
rtl/mem_system.sv
testbench/tb_mem_system.sv

// File: testbench/tb_mem_system.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module tb_mem_system import cache_pkg::*; ();

   localparam int RAND_REQS  = 300;
   localparam int NUM_REQS   = RAND_REQS + 10;
   localparam int WORST_MISS = 6 + 2 * (`MEM_LATENCY + 1); // Write-back plus fill
   localparam int TIMEOUT_NS = (NUM_REQS * (WORST_MISS + 2) + 200) * 8;

   logic                     clk = 1'b0;
   logic                     rst;
   cache_req_t               req;
   logic [`CACHE_DATA_W-1:0] data_out;
   logic                     cache_hit;
   logic                     done;
   logic                     stall;
   logic                     err;

   // Shadow model of memory contents and cache occupancy
   logic [`CACHE_DATA_W-1:0] shadow_mem [logic [`CACHE_ADDR_W-1:0]];
   logic                     shadow_valid [0:`CACHE_LINES-1];
   logic [`CACHE_TAG_W-1:0]  shadow_tag [0:`CACHE_LINES-1];

   logic                     exp_hit;
   logic                     exp_read;
   logic [`CACHE_DATA_W-1:0] exp_data;
   logic                     req_active;
   logic                     last_hit;
   int                       compare_errors = 0;
   int                       check_errors = 0;
   int                       req_count = 0;
   int                       tests_run = 0;
   int                       tests_failed = 0;

   mem_system i_dut (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .data_out  (data_out),
      .cache_hit (cache_hit),
      .done      (done),
      .stall     (stall),
      .err       (err)
   );

   always #4 clk = ~clk;

   function automatic logic [`CACHE_DATA_W-1:0] expected_read(input logic [15:0] addr);
      if (shadow_mem.exists(addr))
         return shadow_mem[addr];
      return addr ^ 16'h5a5a; // Untouched word keeps its preset
   endfunction

   function automatic logic predict_hit(input logic [15:0] addr);
      logic [`CACHE_INDEX_W-1:0] idx;
      idx = addr[`CACHE_INDEX_W-1:0];
      return shadow_valid[idx] && (shadow_tag[idx] == addr[15:`CACHE_INDEX_W]);
   endfunction

   // Checked mid-cycle, where done and data are settled
   always @(negedge clk) begin
      if (!rst) begin
         if (err) begin
            $display("ERROR: err output raised during request %0d", req_count);
            compare_errors++;
         end
         if (done && !req_active) begin
            $display("ERROR: done pulsed with no request pending");
            compare_errors++;
         end else if (done) begin
            if (stall !== 1'b1) begin // Done only pulses outside IDLE
               $display("MISMATCH stall: got %h expected %h", stall, 1'b1);
               compare_errors++;
            end
            if (cache_hit !== exp_hit) begin
               $display("MISMATCH cache_hit: got %h expected %h", cache_hit, exp_hit);
               compare_errors++;
            end
            if (exp_read && (data_out !== exp_data)) begin
               $display("MISMATCH data_out: got %h expected %h", data_out, exp_data);
               compare_errors++;
            end
         end
      end
   end

   // Called at 1 ns after a rising edge, returns at the same point
   task automatic run_request(input logic [15:0] addr, input logic is_write,
                              input logic [15:0] wdata);
      logic [`CACHE_INDEX_W-1:0] idx;
      idx = addr[`CACHE_INDEX_W-1:0];
      if (stall) begin
         $display("ERROR: stall high when request to %h was raised", addr);
         check_errors++;
      end
      exp_hit       = predict_hit(addr);
      exp_data      = expected_read(addr);
      exp_read      = !is_write;
      req.addr.word = addr;
      req.wdata     = wdata;
      req.read      = !is_write;
      req.write     = is_write;
      req_active    = 1'b1;
      @(negedge clk);
      while (!done)
         @(negedge clk);
      last_hit = cache_hit;
      @(posedge clk);
      #1;
      req        = '0;
      req_active = 1'b0;
      shadow_valid[idx] = 1'b1;
      shadow_tag[idx]   = addr[15:`CACHE_INDEX_W];
      if (is_write)
         shadow_mem[addr] = wdata;
      req_count++;
   endtask

   task automatic check_hit_flag(input string what, input logic expected);
      if (last_hit !== expected) begin
         $display("MISMATCH cache_hit (%s): got %h expected %h", what, last_hit, expected);
         check_errors++;
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests_run++;
      if (compare_errors + check_errors != errors_before) begin
         tests_failed++;
         $display("Test %s: fail", name);
      end else begin
         $display("Test %s: ok", name);
      end
   endtask

   initial begin
      int                      base;
      logic [`CACHE_TAG_W-1:0] rand_tag;
      logic [5:0]              rand_idx;

      rst        = 1'b1;
      req        = '0;
      req_active = 1'b0;
      exp_hit    = 1'b0;
      exp_read   = 1'b0;
      exp_data   = '0;
      last_hit   = 1'b0;
      void'($urandom(32'h0d778798));
      for (int i = 0; i < `CACHE_LINES; i++) begin
         shadow_valid[i] = 1'b0;
         shadow_tag[i]   = '0;
      end
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;

      base = check_errors + compare_errors;
      @(negedge clk);
      if (done || cache_hit || stall || err) begin
         $display("ERROR: outputs not idle after reset");
         check_errors++;
      end
      @(posedge clk);
      #1;
      report_test("reset", base);

      base = check_errors + compare_errors;
      run_request(16'h0123, 1'b0, 16'h0000); // Cold miss
      check_hit_flag("cold read", 1'b0);
      run_request(16'h0123, 1'b0, 16'h0000);
      check_hit_flag("repeat read", 1'b1);
      report_test("read_miss_then_hit", base);

      base = check_errors + compare_errors;
      run_request(16'h0123, 1'b1, 16'hbeef);
      check_hit_flag("write hit", 1'b1);
      run_request(16'h0123, 1'b0, 16'h0000);
      check_hit_flag("read after write", 1'b1);
      report_test("write_hit", base);

      // Same index 5, tags 9 and 0x21
      base = check_errors + compare_errors;
      run_request(16'h0245, 1'b1, 16'hc0de);
      run_request(16'h0845, 1'b0, 16'h0000);
      check_hit_flag("conflicting read", 1'b0);
      run_request(16'h0245, 1'b0, 16'h0000);
      check_hit_flag("evicted read", 1'b0);
      report_test("dirty_eviction", base);

      base = check_errors + compare_errors;
      for (int n = 0; n < RAND_REQS; n++) begin
         rand_tag = 10'($urandom_range(3, 0));
         rand_idx = 6'($urandom_range(3, 0));
         run_request({rand_tag, rand_idx}, 1'($urandom_range(1, 0)), 16'($urandom));
      end
      report_test("random", base);

      $display("Summary: %0d tests, %0d failed, %0d requests, %0d errors",
               tests_run, tests_failed, req_count, compare_errors + check_errors);
      if (tests_failed == 0 && compare_errors + check_errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: no done pulse in time, stopped after %0d requests", req_count);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire
